//--- all.f
+incdir+src
src/rdp_ctrl_pkg.sv
src/rdp_data_pkg.sv
src/rdp_read_timing.sv
src/rdp_group_fifo.sv
src/rdp_valid_predict.sv
src/rdp_rdata_out.sv
src/rdp_read_datapath.sv
verif/rdp_chk.sv
verif/tb_read_datapath.sv

//--- Makefile
# Verilator flow for the read datapath testbench
VERILATOR ?= verilator
TOP ?= tb_read_datapath
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/1ps -j 0
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | awk '{ print } /$(PASS_TEXT)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_read_datapath.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

module tb_read_datapath;

	localparam int G = `RDP_NUM_GROUPS;
	localparam int S = `RDP_NUM_SLOTS;
	localparam int W = `RDP_GROUP_WIDTH;
	localparam int RESET_CYCLES = 16;
	// Fifteen bursts, each one quiet again within 40 cycles
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 15 * 40 + 100;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic rdata_en_i;
	rdp_ctrl_pkg::seq_ctrl_t seq_ctrl_i;
	rdp_data_pkg::capture_t capture_i;
	rdp_data_pkg::afi_word_t afi_rdata_o;
	rdp_data_pkg::afi_word_t seq_rdata_o;
	logic afi_rdata_valid_o;
	rdp_ctrl_pkg::group_mask_t dqs_enable_ctrl_o;
	logic force_oct_off_o;

	// Expected outputs of the current cycle
	logic exp_valid;
	rdp_ctrl_pkg::group_mask_t exp_dqs;
	logic exp_oct_off;
	rdp_data_pkg::afi_word_t exp_afi;
	rdp_data_pkg::afi_word_t exp_seq;

	// Expected events indexed by cycle number
	logic valid_at [1024];
	logic oct_win_at [1024];
	rdp_ctrl_pkg::group_mask_t dqs_at [1024];
	// Beats of all groups captured together, oldest first
	rdp_data_pkg::group_beat_t [G-1:0] beat_q [$];
	// Prediction address steps per group
	int inc_cnt [G];
	int cyc;
	int last_evt;
	logic [31:0] lfsr;

	rdp_read_datapath uut (.*);

	bind rdp_read_datapath rdp_chk u_chk
	(
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_i (afi_rdata_o),
		.seq_rdata_i (seq_rdata_o),
		.afi_rdata_valid_i (afi_rdata_valid_o),
		.dqs_enable_ctrl_i (dqs_enable_ctrl_o),
		.force_oct_off_i (force_oct_off_o),
		.exp_valid_i (tb_read_datapath.exp_valid),
		.exp_dqs_i (tb_read_datapath.exp_dqs),
		.exp_oct_off_i (tb_read_datapath.exp_oct_off),
		.exp_afi_i (tb_read_datapath.exp_afi),
		.exp_seq_i (tb_read_datapath.exp_seq)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever
			#50 pll_afi_clk = ~pll_afi_clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge pll_afi_clk);
		$display("Watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// **************************************************
	// Reference model
	// **************************************************

	// Steps past the next rising edge, clears pulses and publishes expectations
	task automatic next_cycle();
		rdp_data_pkg::group_beat_t [G-1:0] head;
		@(posedge pll_afi_clk);
		#1;
		cyc++;
		rdata_en_i = 1'b0;
		capture_i = '0;
		seq_ctrl_i.inc_vfifo = '0;
		seq_ctrl_i.fifo_reset = '0;
		exp_valid = valid_at[cyc];
		exp_dqs = dqs_at[cyc];
		exp_oct_off = (cyc > RESET_CYCLES) && !oct_win_at[cyc];
		if (exp_valid && beat_q.size() != 0)
		begin
			head = beat_q.pop_front();
			// AFI word is slot-major, sequencer word is group-major
			for (int g = 0; g < G; g++)
				for (int s = 0; s < S; s++)
				begin
					exp_afi[(s * G + g) * W +: W] = head[g][s * W +: W];
					exp_seq[(g * S + s) * W +: W] = head[g][s * W +: W];
				end
		end
	endtask

	// One read enable with the beats it will return, all groups strobed
	task automatic issue_read(input int lat);
		rdp_data_pkg::group_beat_t [G-1:0] beats;
		beats = rand_bits(G * S * W);
		rdata_en_i = 1'b1;
		capture_i.strobe = '1;
		capture_i.beat = beats;
		beat_q.push_back(beats);
		valid_at[cyc + lat + 1] = 1'b1;
		for (int g = 0; g < G; g++)
			dqs_at[cyc + `RDP_QVLD_EXTRA + inc_cnt[g] % (2 ** `RDP_VFIFO_AW) + 1][g] = 1'b1;
		// OCT-off is released over the window that follows the enable
		for (int d = `RDP_OCT_ON_DELAY + 1; d <= `RDP_OCT_OFF_DELAY + 1; d++)
			oct_win_at[cyc + d] = 1'b1;
		// Enable has left both shifters by then
		last_evt = cyc + `RDP_MAX_LATENCY + `RDP_QVLD_EXTRA + (2 ** `RDP_VFIFO_AW);
	endtask

	// Back-to-back reads at one latency, then idle until every event passed
	task automatic run_burst(input int lat, input int max_len);
		int len;
		len = 1 + int'(rand_bits(2)) % max_len;
		seq_ctrl_i.read_latency = rdp_ctrl_pkg::latency_t'(lat);
		repeat (len)
		begin
			next_cycle();
			issue_read(lat);
		end
		while (beat_q.size() != 0 || cyc <= last_evt)
			next_cycle();
	endtask

	// Prediction address steps, applied only while no token is in flight
	task automatic pulse_inc(input int g, input int n);
		repeat (n)
		begin
			next_cycle();
			seq_ctrl_i.inc_vfifo[g] = 1'b1;
			inc_cnt[g]++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s finished, assertion failures so far %0d",
			num, name, uut.u_chk.err_count);
	endtask

	// **************************************************
	// Tests
	// **************************************************
	initial
	begin
		rdata_en_i = 1'b0;
		seq_ctrl_i = '0;
		capture_i = '0;
		reset_n_afi_clk = 1'b0;
		exp_valid = 1'b0;
		exp_dqs = '0;
		exp_oct_off = 1'b0;
		exp_afi = '0;
		exp_seq = '0;
		lfsr = 32'hb4ea_8a9b;
		cyc = 0;
		last_evt = 0;
		inc_cnt = '{default: 0};
		for (int i = 0; i < 1024; i++)
		begin
			valid_at[i] = 1'b0;
			oct_win_at[i] = 1'b0;
			dqs_at[i] = '0;
		end
		repeat (RESET_CYCLES)
			next_cycle();
		reset_n_afi_clk = 1'b1;
		repeat (4)
			next_cycle();
		report_test(1, "reset state");
		// Latency extremes, then random settings
		run_burst(1, 4);
		run_burst(15, 4);
		repeat (4)
			run_burst(1 + int'(rand_bits(4)) % 15, 4);
		report_test(2, "read latency");
		repeat (2)
			run_burst(1 + int'(rand_bits(4)) % 15, 4);
		// A beat captured with no read enable stays in both FIFOs
		next_cycle();
		capture_i.strobe = '1;
		capture_i.beat = rand_bits(G * S * W);
		beat_q.push_back(capture_i.beat);
		// Both FIFOs restart from entry 0 while the model queue is empty
		next_cycle();
		seq_ctrl_i.fifo_reset = '1;
		beat_q.delete();
		repeat (2)
			run_burst(1 + int'(rand_bits(4)) % 15, 4);
		report_test(3, "data order");
		// Only group 1 is delayed so the groups part ways
		pulse_inc(1, 3);
		run_burst(1 + int'(rand_bits(4)) % 15, 4);
		pulse_inc(1, 2);
		run_burst(1 + int'(rand_bits(4)) % 15, 4);
		report_test(4, "valid prediction");
		repeat (3)
			run_burst(1 + int'(rand_bits(4)) % 15, 1);
		report_test(5, "OCT window");
		next_cycle();
		$display("5 tests run, %0d assertion failures", uut.u_chk.err_count);
		if (uut.u_chk.err_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verif/rdp_chk.sv
`timescale 1ns/1ps

// Assertions on the read datapath outputs
// Expected values come from the testbench reference models
module rdp_chk
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input rdp_data_pkg::afi_word_t afi_rdata_i,
	input rdp_data_pkg::afi_word_t seq_rdata_i,
	input logic afi_rdata_valid_i,
	input rdp_ctrl_pkg::group_mask_t dqs_enable_ctrl_i,
	input logic force_oct_off_i,
	input logic exp_valid_i,
	input rdp_ctrl_pkg::group_mask_t exp_dqs_i,
	input logic exp_oct_off_i,
	input rdp_data_pkg::afi_word_t exp_afi_i,
	input rdp_data_pkg::afi_word_t exp_seq_i
);

	// Failed assertions so far
	int err_count = 0;

	task automatic count_failure(input string msg);
		$error("%s", msg);
		err_count++;
	endtask

	// **************************************************
	// Reset and timing
	// **************************************************

	// All status outputs are low in the first cycle out of reset
	reset_state: assert property (@(posedge pll_afi_clk) $rose(reset_n_afi_clk)
		|-> !afi_rdata_valid_i && dqs_enable_ctrl_i == '0 && !force_oct_off_i)
		else count_failure("Outputs were not idle when reset was released");

	// Read-valid follows each enable by the latency plus the output register
	valid_timing: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_i == exp_valid_i)
		else count_failure($sformatf("Mismatch afi_rdata_valid_o: got %h expected %h",
			$sampled(afi_rdata_valid_i), $sampled(exp_valid_i)));

	// **************************************************
	// Data order, prediction and termination
	// **************************************************

	afi_order: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_i |-> afi_rdata_i == exp_afi_i)
		else count_failure($sformatf("Mismatch afi_rdata_o: got %h expected %h",
			$sampled(afi_rdata_i), $sampled(exp_afi_i)));

	seq_order: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_i |-> seq_rdata_i == exp_seq_i)
		else count_failure($sformatf("Mismatch seq_rdata_o: got %h expected %h",
			$sampled(seq_rdata_i), $sampled(exp_seq_i)));

	// Each group's DQS enable carries its own calibrated delay
	dqs_timing: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		dqs_enable_ctrl_i == exp_dqs_i)
		else count_failure($sformatf("Mismatch dqs_enable_ctrl_o: got %h expected %h",
			$sampled(dqs_enable_ctrl_i), $sampled(exp_dqs_i)));

	oct_window: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off_i == exp_oct_off_i)
		else count_failure($sformatf("Mismatch force_oct_off_o: got %h expected %h",
			$sampled(force_oct_off_i), $sampled(exp_oct_off_i)));

endmodule

//--- src/rdp_read_datapath.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

// **************************************************
// Read datapath top level
// **************************************************
// One latency selector serves every group since they share one setting
// Each DQS group has its own data FIFO and valid-prediction shifter
module rdp_read_datapath
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic rdata_en_i,
	input rdp_ctrl_pkg::seq_ctrl_t seq_ctrl_i,
	input rdp_data_pkg::capture_t capture_i,
	output rdp_data_pkg::afi_word_t afi_rdata_o,
	output rdp_data_pkg::afi_word_t seq_rdata_o,
	output logic afi_rdata_valid_o,
	output rdp_ctrl_pkg::group_mask_t dqs_enable_ctrl_o,
	output logic force_oct_off_o
);

	// FIFO read enable, L cycles after the controller's enable
	logic read_enable;
	// FIFO heads feeding the output registers
	rdp_data_pkg::group_beat_t group_beats [`RDP_NUM_GROUPS];

	rdp_read_timing u_read_timing
	(
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i (rdata_en_i),
		.read_latency_i (seq_ctrl_i.read_latency),
		.read_enable_o (read_enable),
		.force_oct_off_o (force_oct_off_o)
	);

	for (genvar g = 0; g < `RDP_NUM_GROUPS; g++)
	begin : group_gen
		rdp_group_fifo u_group_fifo
		(
			.pll_afi_clk (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.wr_strobe_i (capture_i.strobe[g]),
			.wr_beat_i (capture_i.beat[g]),
			.rd_en_i (read_enable),
			.ptr_reset_i (seq_ctrl_i.fifo_reset[g]),
			.rd_beat_o (group_beats[g])
		);

		// The controller's enable is the token source
		rdp_valid_predict u_valid_predict
		(
			.pll_afi_clk (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.token_i (rdata_en_i),
			.inc_wr_addr_i (seq_ctrl_i.inc_vfifo[g]),
			.qvld_o (dqs_enable_ctrl_o[g])
		);
	end

	rdp_rdata_out u_rdata_out
	(
		.pll_afi_clk (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.read_enable_i (read_enable),
		.group_beats_i (group_beats),
		.afi_rdata_o (afi_rdata_o),
		.seq_rdata_o (seq_rdata_o),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

endmodule

//--- src/rdp_rdata_out.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

// Output registers of the read datapath
// The beats of all groups are captured together on the read enable
module rdp_rdata_out
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic read_enable_i,
	input rdp_data_pkg::group_beat_t group_beats_i [`RDP_NUM_GROUPS],
	output rdp_data_pkg::afi_word_t afi_rdata_o,
	output rdp_data_pkg::afi_word_t seq_rdata_o,
	output logic afi_rdata_valid_o
);

	localparam int G = `RDP_NUM_GROUPS;
	localparam int S = `RDP_NUM_SLOTS;
	localparam int W = `RDP_GROUP_WIDTH;

	rdp_data_pkg::afi_word_t afi_next;
	rdp_data_pkg::afi_word_t seq_next;

	// AFI word is slot-major so slot s of group g lands in field s*G+g
	// Sequencer word is group-major so the same beat lands in field g*S+s
	always_comb
	begin
		afi_next = '0;
		seq_next = '0;
		for (int g = 0; g < G; g++)
		begin
			for (int s = 0; s < S; s++)
			begin
				afi_next[(s*G+g)*W +: W] = group_beats_i[g][s*W +: W];
				seq_next[(g*S+s)*W +: W] = group_beats_i[g][s*W +: W];
			end
		end
	end

	// Data is held between read enables
	always_ff @(posedge pll_afi_clk)
	begin
		if (read_enable_i)
		begin
			afi_rdata_o <= afi_next;
			seq_rdata_o <= seq_next;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= read_enable_i;
	end

endmodule

//--- src/rdp_valid_predict.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

// Valid prediction for one DQS group
// Every cycle a token, set for a read enable, enters a shift register
// It is written at a stage set by calibration and comes out at stage 0
// The output drives the group's DQS enable control
module rdp_valid_predict
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic token_i,
	input logic inc_wr_addr_i,
	output logic qvld_o
);

	localparam int AW = `RDP_VFIFO_AW;
	localparam int EXTRA = `RDP_QVLD_EXTRA;
	localparam int LEN = (2 ** AW) + EXTRA;

	// Write address stepped by the sequencer during calibration
	logic [AW-1:0] wr_addr;
	// Stage that receives the token, one bit wider than the address
	logic [AW:0] wr_stage;
	// Token shifter, moving toward index 0
	logic [LEN-1:0] qvld_shifter;
	logic [LEN-1:0] qvld_next;

	assign wr_stage = {1'b0, wr_addr} + (AW + 1)'(EXTRA);

	// Shift by one and drop the incoming token at the write stage
	always_comb
	begin
		qvld_next = {1'b0, qvld_shifter[LEN-1:1]};
		qvld_next[wr_stage] = token_i;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_addr <= '0;
			qvld_shifter <= '0;
		end
		else
		begin
			qvld_shifter <= qvld_next;
			// Each pulse adds one cycle of delay, wrapping after eight
			if (inc_wr_addr_i)
				wr_addr <= wr_addr + 1'b1;
		end
	end

	assign qvld_o = qvld_shifter[0];

endmodule

//--- src/rdp_group_fifo.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

// Read data FIFO of one DQS group
// Captured beats are written on the capture strobe
// The head entry is shown combinationally until the read enable pops it
module rdp_group_fifo
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic wr_strobe_i,
	input rdp_data_pkg::group_beat_t wr_beat_i,
	input logic rd_en_i,
	input logic ptr_reset_i,
	output rdp_data_pkg::group_beat_t rd_beat_o
);

	localparam int DEPTH = `RDP_FIFO_DEPTH;
	localparam int AW = `RDP_FIFO_AW;

	// Beat storage
	rdp_data_pkg::group_beat_t fifo_mem [DEPTH];

	// Both pointers wrap naturally since the depth is a power of two
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;

	// **************************************************
	// Storage write
	// **************************************************
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_strobe_i)
			fifo_mem[wr_ptr] <= wr_beat_i;
	end

	// Pointer control
	// The sequencer's FIFO reset clears both pointers and wins over any step
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (ptr_reset_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_strobe_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en_i)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Head of the queue, registered downstream
	assign rd_beat_o = fifo_mem[rd_ptr];

endmodule

//--- src/rdp_read_timing.sv
`timescale 1ns/1ps
`include "rdp_cfg.svh"

// Read latency timing and termination control
// The controller's read-data enable runs down a shift register
// The sequencer's latency setting picks the tap that reads the data FIFOs
module rdp_read_timing
(
	input logic pll_afi_clk,
	input logic reset_n_afi_clk,
	input logic rdata_en_i,
	input rdp_ctrl_pkg::latency_t read_latency_i,
	output logic read_enable_o,
	output logic force_oct_off_o
);

	localparam int MAX_LAT = `RDP_MAX_LATENCY;
	localparam int OCT_ON = `RDP_OCT_ON_DELAY;
	localparam int OCT_OFF = `RDP_OCT_OFF_DELAY;

	// **************************************************
	// Latency shifter
	// **************************************************

	// Bit i holds the enable sampled i+1 edges ago
	logic [MAX_LAT-1:0] latency_shifter;
	// A setting of L selects bit L-1
	rdp_ctrl_pkg::latency_t tap_sel;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			latency_shifter <= '0;
		else
			latency_shifter <= {latency_shifter[MAX_LAT-2:0], rdata_en_i};
	end

	// A setting of zero wraps to the last stage
	assign tap_sel = read_latency_i - 1'b1;
	assign read_enable_o = latency_shifter[tap_sel];

	// **************************************************
	// OCT-off window
	// **************************************************

	// Recent enable history kept apart from the latency shifter
	logic [OCT_OFF-1:0] oct_hist;
	// Current enable plus history, index 0 is this cycle
	logic [OCT_OFF:0] oct_window;

	assign oct_window = {oct_hist, rdata_en_i};

	// Termination is forced off unless a read enable lies in the window
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			oct_hist <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			oct_hist <= oct_window[OCT_OFF-1:0];
			force_oct_off_o <= ~(|oct_window[OCT_OFF:OCT_ON]);
		end
	end

endmodule

//--- src/rdp_data_pkg.sv
`include "rdp_cfg.svh"

// **************************************************
// Data-side types for captured beats and AFI read words
// **************************************************
package rdp_data_pkg;

	// One DQS group's data for all time slots of an AFI cycle
	// Slot 0 sits in the low group-width bits
	typedef logic [`RDP_NUM_SLOTS*`RDP_GROUP_WIDTH-1:0] group_beat_t;

	// Captured read data as it leaves the capture registers
	// A strobe bit marks a valid beat for that group in this cycle
	typedef struct packed
	{
		rdp_ctrl_pkg::group_mask_t strobe;
		// Group 0 beat in the low bits
		group_beat_t [`RDP_NUM_GROUPS-1:0] beat;
	} capture_t;

	// Full read word covering every group and every time slot
	// The AFI bus orders it by slot then group
	// The sequencer bus orders it by group then slot
	typedef logic [`RDP_NUM_GROUPS*`RDP_NUM_SLOTS*`RDP_GROUP_WIDTH-1:0] afi_word_t;

endpackage

//--- src/rdp_ctrl_pkg.sv
`include "rdp_cfg.svh"

// **************************************************
// Control-side types shared by the sequencer and the controller
// **************************************************
package rdp_ctrl_pkg;

	// Read latency in whole AFI cycles, legal range 1 to 15
	typedef logic [`RDP_LAT_W-1:0] latency_t;

	// One bit per DQS group
	typedef logic [`RDP_NUM_GROUPS-1:0] group_mask_t;

	// Sequencer calibration controls
	// The latency is held static while reads are in flight
	// Both masks are single-cycle pulses per group
	typedef struct packed
	{
		// Selects the tap of the read latency shifter
		latency_t read_latency;
		// Steps a group's valid-prediction write address by one cycle
		group_mask_t inc_vfifo;
		// Clears both pointers of a group's read data FIFO
		group_mask_t fifo_reset;
	} seq_ctrl_t;

endpackage

//--- src/rdp_cfg.svh
`ifndef RDP_CFG_SVH
`define RDP_CFG_SVH

// Interface shape
`define RDP_NUM_GROUPS 2
`define RDP_GROUP_WIDTH 4
`define RDP_NUM_SLOTS 4

// Read data FIFO, one per DQS group
`define RDP_FIFO_DEPTH 8
`define RDP_FIFO_AW 3

// Read latency shifter and the width of the sequencer's latency setting
`define RDP_MAX_LATENCY 16
`define RDP_LAT_W 4

// Valid prediction token shifter
`define RDP_VFIFO_AW 3
`define RDP_QVLD_EXTRA 2

// OCT window, derived from the memory read latency tRL
`define RDP_MEM_T_RL 5
`define RDP_OCT_ON_DELAY ((`RDP_MEM_T_RL > 4) ? ((`RDP_MEM_T_RL - 4) / 2) : 0)
`define RDP_OCT_OFF_DELAY ((`RDP_MEM_T_RL + 6) / 2)

`endif
